// ==== Makefile ====
# Verilator build and run of the constraint solver testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_constraint_solver
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test passed" $(LOG); then echo "simulation ok"; \
	else echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_constraint_solver.sv ====
`timescale 1ns/1ns
/*
 * constraint solver testbench
 * random clause sets checked against a clause model, plus reset,
 * contradiction, done-pulse and mid-run reset scenarios
 */
module tb_constraint_solver
    import solver_cfg_pkg::*;
    import clause_pkg::*;
();

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     start;
    clause_set_t              clauses;
    logic                     busy;
    logic                     done;
    logic                     sat;
    int_vals_t                int_vals;
    bool_vals_t               bool_vals;
    logic [attempt_width-1:0] attempts;

    int seed = 47951;     // fixed seed, repeatable clause sets
    int solved = 0;       // random sets that came back satisfied

    always #2 clk = ~clk; // 4 ns period

    constraint_solver_top dut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .clauses   (clauses),
        .busy      (busy),
        .done      (done),
        .sat       (sat),
        .int_vals  (int_vals),
        .bool_vals (bool_vals),
        .attempts  (attempts)
    );

    //////////////////////////////////////////////////////////////////////
    // helpers
    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    // clause c holds when a present literal matches its polarity,
    // or when the exact sum of coef*y plus bias is <= 0
    task automatic model_sat(input clause_set_t cs, input int_vals_t y,
                             input bool_vals_t x, output sat_vec_t holds);
        int   acc;
        logic lit;
        for (int c = 0; c < num_clauses; c++)
        begin
            lit = 1'b0;
            acc = int'($signed(cs[c].bias));                // full 32-bit width
            for (int v = 0; v < num_int_vars; v++)
                acc = acc + int'($signed(cs[c].coef[v])) * int'($signed(y[v]));
            for (int b = 0; b < num_bool_vars; b++)
                if (cs[c].lits[b].present && cs[c].lits[b].polarity == x[b])
                    lit = 1'b1;
            holds[c] = lit || (acc <= 0);
        end
    endtask

    task automatic random_clause_set(output clause_set_t cs);
        int r;
        for (int c = 0; c < num_clauses; c++)
        begin
            for (int v = 0; v < num_int_vars; v++)
            begin
                r = $random(seed);
                cs[c].coef[v] = r[7:0];
            end
            r = $random(seed);
            cs[c].bias = r[7:0];
            for (int b = 0; b < num_bool_vars; b++)
            begin
                r = $random(seed);
                cs[c].lits[b].present  = (r[9:8] == 2'b00);  // literal in about 1 of 4
                cs[c].lits[b].polarity = r[10];
            end
        end
    endtask

    // one-cycle start, busy must be up the cycle after
    task automatic pulse_start(input clause_set_t cs);
        @(posedge clk);
        start   <= 1'b1;
        clauses <= cs;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        assert (busy)
            else stop_on_error($sformatf("** Error at %0t ns: busy low after start", $time));
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < max_attempts + 20)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!done)
            stop_on_error($sformatf("no done pulse within %0d cycles, the solver is stuck",
                                    max_attempts + 20));
        else
        begin
            assert (!busy)
                else stop_on_error($sformatf("** Error at %0t ns: busy high with done", $time));
            @(negedge clk);
            assert (!done && !busy)                     // single pulse, run closed
                else stop_on_error($sformatf("** Error at %0t ns: done %0b busy %0b after done",
                                             $time, done, busy));
        end
    endtask

    task automatic check_quiet(input int n);
        repeat (n)
        begin
            @(negedge clk);
            assert (!done && !busy)
                else stop_on_error($sformatf("** Error at %0t ns: done %0b busy %0b while idle",
                                             $time, done, busy));
        end
    endtask

    task automatic check_result(input clause_set_t cs);
        sat_vec_t holds;
        if (sat)
        begin
            model_sat(cs, int_vals, bool_vals, holds);
            assert (&holds)
                else stop_on_error($sformatf("** Error at %0t ns: result breaks clauses %b",
                                             $time, ~holds));
            assert (int'(attempts) >= 1 && int'(attempts) <= max_attempts)
                else stop_on_error($sformatf("** Error at %0t ns: attempts %0d out of range",
                                             $time, attempts));
        end
        else
            assert (int'(attempts) == max_attempts)     // failure only at the limit
                else stop_on_error($sformatf("** Error at %0t ns: unsat after %0d attempts",
                                             $time, attempts));
    endtask

    //////////////////////////////////////////////////////////////////////
    // scenarios
    initial
    begin
        clause_set_t cs;
        clause_set_t contra;

        reset   <= 1'b1;
        start   <= 1'b0;
        clauses <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // quiet after reset, sat low too
        check_quiet(10);
        assert (!sat)
            else stop_on_error($sformatf("** Error at %0t ns: sat high after reset", $time));

        // all-zero clauses hold for any candidate, first attempt wins
        cs = '0;
        pulse_start(cs);
        wait_done();
        assert (sat && attempts == 8'd1)
            else stop_on_error($sformatf("** Error at %0t ns: trivial set gave sat %0b attempts %0d",
                                         $time, sat, attempts));

        for (int n = 0; n < 40; n++)
        begin
            random_clause_set(cs);
            pulse_start(cs);
            wait_done();
            check_result(cs);
            if (sat)
                solved++;
        end
        $display("random clause sets solved: %0d of 40", solved);

        // x0 and !x0 with positive bias, never both hold
        contra = '0;
        contra[0].bias             = 8'sd1;
        contra[0].lits[0].present  = 1'b1;
        contra[0].lits[0].polarity = 1'b1;
        contra[1].bias             = 8'sd1;
        contra[1].lits[0].present  = 1'b1;
        contra[1].lits[0].polarity = 1'b0;
        pulse_start(contra);
        wait_done();
        assert (!sat && int'(attempts) == max_attempts)
            else stop_on_error($sformatf("** Error at %0t ns: contradiction gave sat %0b attempts %0d",
                                         $time, sat, attempts));

        // start while busy is dropped, clause set stays the captured one
        pulse_start(contra);
        repeat (10) @(posedge clk);
        random_clause_set(cs);
        pulse_start(cs);
        wait_done();
        assert (!sat && int'(attempts) == max_attempts)
            else stop_on_error($sformatf("** Error at %0t ns: busy start disturbed the run",
                                         $time));
        check_quiet(12);                                // no second done

        // reset in the middle of a long run
        pulse_start(contra);
        repeat (20) @(posedge clk);
        reset <= 1'b1;
        repeat (5)
        begin
            @(posedge clk);
            @(negedge clk);
            assert (!busy && !done)
                else stop_on_error($sformatf("** Error at %0t ns: busy or done during reset",
                                             $time));
        end
        @(posedge clk);
        reset <= 1'b0;
        check_quiet(5);
        random_clause_set(cs);
        pulse_start(cs);
        wait_done();
        check_result(cs);

        $display("Test passed");
        $finish;
    end

endmodule

// ==== src.f ====
verilog/solver_cfg_pkg.sv
verilog/clause_pkg.sv
verilog/candidate_if.sv
verilog/candidate_gen.sv
verilog/clause_checker.sv
verilog/solution_select.sv
verilog/constraint_solver_top.sv
dv/tb_constraint_solver.sv

// ==== verilog/candidate_gen.sv ====
`timescale 1ns/1ns
/*
 * candidate generator
 * galois lfsr driven source of one random assignment per cycle,
 * numbered from zero, until stopped or out of attempts
 */
module candidate_gen
    import solver_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        stop,
    candidate_if.source cand
);

    logic [lfsr_width-1:0] lfsr;
    logic [lfsr_width-1:0] lfsr_next;
    logic                  session;     // run open on the selector side
    logic                  idle;
    logic                  take_start;
    logic                  last;        // current candidate is the final attempt
    logic                  emit;        // candidate goes out next cycle

    // shift right, fold the taps back in when a one drops out
    assign lfsr_next = lfsr[0] ? ({1'b0, lfsr[lfsr_width-1:1]} ^ lfsr_taps)
                               : {1'b0, lfsr[lfsr_width-1:1]};

    // stop stays up from the decision until the next start,
    // so it also marks the selector as free again
    assign idle       = !session || stop;
    assign take_start = start && idle;     // start during a run is dropped
    assign last       = cand.attempt == attempt_width'(max_attempts - 1);
    assign emit       = take_start || (cand.valid && !stop && !last);

    //////////////////////////////////////////////////////////////////////
    // control
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lfsr       <= lfsr_seed;    // repeatable sequence after reset
            session    <= 1'b0;
            cand.valid <= 1'b0;
        end
        else
        begin
            if (take_start)
                session <= 1'b1;
            else if (stop)
                session <= 1'b0;        // selector has decided
            cand.valid <= emit;
            if (emit)
                lfsr <= lfsr_next;      // runs on, so each start sees new values
        end
    end

    //////////////////////////////////////////////////////////////////////
    // payload
    always_ff @(posedge clk)
    begin
        if (emit)
        begin
            // low bytes of the state feed the integers
            for (int v = 0; v < num_int_vars; v++)
                cand.int_vals[v] <= lfsr[v*int_var_width +: int_var_width];
            cand.bool_vals <= lfsr[lfsr_width-1 -: num_bool_vars];  // top bits
            cand.attempt   <= take_start ? '0 : cand.attempt + 1'b1;
        end
    end

    // a new burst only begins once the selector has dropped stop
    assert property (@(posedge clk) disable iff (reset)
        $rose(cand.valid) |-> !stop);

endmodule

// ==== verilog/candidate_if.sv ====
`timescale 1ns/1ns
/*
 * candidate link
 * one candidate assignment moving between pipeline stages
 */
interface candidate_if
    import solver_cfg_pkg::*;
    import clause_pkg::*;
();

    logic                     valid;      // one-cycle strobe per candidate
    int_vals_t                int_vals;
    bool_vals_t               bool_vals;
    logic [attempt_width-1:0] attempt;    // index since start, from 0

    // stage that produces the candidate
    modport source (output valid, int_vals, bool_vals, attempt);

    // stage that consumes it
    modport sink (input valid, int_vals, bool_vals, attempt);

endinterface

// ==== verilog/clause_checker.sv ====
`timescale 1ns/1ns
/*
 * clause checker
 * two-stage evaluation of every clause against a candidate,
 * linear part computed at full width
 */
module clause_checker
    import solver_cfg_pkg::*;
    import clause_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  clause_set_t clauses,
    candidate_if.sink   cand_in,
    candidate_if.source cand_out,
    output sat_vec_t    sat
);

    clause_set_t clauses_q;   // clause set held for the whole run
    logic        armed;       // open run that mirrors busy of the selector
    logic        take_start;
    logic        decided;     // selector takes the candidate now at the output

    logic                        s1_valid;
    int_vals_t                   s1_int_vals;
    bool_vals_t                  s1_bool_vals;
    logic [attempt_width-1:0]    s1_attempt;
    logic signed [sum_width-1:0] prod_q [num_clauses][num_int_vars];
    sat_vec_t                    lit_hit;
    sat_vec_t                    lit_hit_q;
    logic signed [sum_width-1:0] lin_sum [num_clauses];

    assign take_start = start && !armed;
    assign decided    = cand_out.valid
                        && (&sat || cand_out.attempt == attempt_width'(max_attempts - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
            armed <= 1'b0;
        else if (take_start)
            armed <= 1'b1;
        else if (decided)
            armed <= 1'b0;          // same cycle the selector drops busy
    end

    always_ff @(posedge clk)
    begin
        if (take_start)
            clauses_q <= clauses;
    end

    //////////////////////////////////////////////////////////////////////
    // stage one products and literal matches
    always_comb
    begin
        lit_hit = '0;
        for (int c = 0; c < num_clauses; c++)
            for (int b = 0; b < num_bool_vars; b++)
                if (clauses_q[c].lits[b].present
                    && clauses_q[c].lits[b].polarity == cand_in.bool_vals[b])
                    lit_hit[c] = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            s1_valid <= 1'b0;
        else
            s1_valid <= cand_in.valid && !take_start;   // new run flushes old ones
    end

    always_ff @(posedge clk)
    begin
        s1_int_vals  <= cand_in.int_vals;
        s1_bool_vals <= cand_in.bool_vals;
        s1_attempt   <= cand_in.attempt;
        lit_hit_q    <= lit_hit;
        for (int c = 0; c < num_clauses; c++)
            for (int v = 0; v < num_int_vars; v++)
                prod_q[c][v] <= clauses_q[c].coef[v] * cand_in.int_vals[v];  // exact at sum width
    end

    //////////////////////////////////////////////////////////////////////
    // stage two sums, compares and realigns the candidate
    always_comb
    begin
        for (int c = 0; c < num_clauses; c++)
        begin
            lin_sum[c] = clauses_q[c].bias;          // sign extended
            for (int v = 0; v < num_int_vars; v++)
                lin_sum[c] = lin_sum[c] + prod_q[c][v];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            cand_out.valid <= 1'b0;
        else
            cand_out.valid <= s1_valid && !take_start;
    end

    always_ff @(posedge clk)
    begin
        cand_out.int_vals  <= s1_int_vals;
        cand_out.bool_vals <= s1_bool_vals;
        cand_out.attempt   <= s1_attempt;
        for (int c = 0; c < num_clauses; c++)
            sat[c] <= lit_hit_q[c] || (lin_sum[c] <= 0);
    end

    // a candidate with no start around it leaves two cycles later with its own index
    assert property (@(posedge clk) disable iff (reset)
        $past(cand_in.valid && !start && !reset, 2) && $past(!start && !reset)
        |-> cand_out.valid && cand_out.attempt == $past(cand_in.attempt, 2));

    // clause set only changes on an accepted start
    assert property (@(posedge clk) disable iff (reset)
        !$stable(clauses_q) |-> $past(start));

endmodule

// ==== verilog/clause_pkg.sv ====
/*
 * clause types
 * clause, clause set and assignment layouts built on the solver sizes
 */
package clause_pkg;

    import solver_cfg_pkg::*;

    // one integer variable or one coefficient
    typedef logic signed [int_var_width-1:0] int_val_t;

    // boolean literal slot of a clause
    typedef struct packed {
        logic present;     // literal appears in the clause
        logic polarity;    // 1 means x, 0 means !x
    } bool_lit_t;

    // clause holds when a present literal matches,
    // or when sum(coef[i] * y[i]) + bias <= 0
    typedef struct packed {
        bool_lit_t [num_bool_vars-1:0] lits;
        int_val_t  [num_int_vars-1:0]  coef;
        logic signed [bias_width-1:0]  bias;
    } clause_t;

    typedef clause_t [num_clauses-1:0] clause_set_t;

    ////////////////////////////////////////////////////////////////////
    // candidate assignment
    typedef int_val_t [num_int_vars-1:0] int_vals_t;   // y values, signed each
    typedef logic [num_bool_vars-1:0]    bool_vals_t;  // x values

    // bit c set when clause c holds
    typedef logic [num_clauses-1:0] sat_vec_t;

endpackage

// ==== verilog/constraint_solver_top.sv ====
`timescale 1ns/1ns
/*
 * constraint solver top
 * generator, clause checker and selector in one pipeline
 */
module constraint_solver_top
    import solver_cfg_pkg::*;
    import clause_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,     // pulse, ignored while busy
    input  clause_set_t              clauses,   // sampled on start
    output logic                     busy,
    output logic                     done,      // result valid this cycle
    output logic                     sat,       // low when attempts ran out
    output int_vals_t                int_vals,
    output bool_vals_t               bool_vals,
    output logic [attempt_width-1:0] attempts
);

    candidate_if gen_cand ();   // generator to checker
    candidate_if chk_cand ();   // checker to selector

    logic     stop;
    sat_vec_t chk_sat;

    candidate_gen u_gen (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .stop  (stop),
        .cand  (gen_cand.source)
    );

    clause_checker u_chk (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .clauses  (clauses),
        .cand_in  (gen_cand.sink),
        .cand_out (chk_cand.source),
        .sat      (chk_sat)
    );

    solution_select u_sel (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .cand      (chk_cand.sink),
        .sat       (chk_sat),
        .stop      (stop),
        .busy      (busy),
        .done      (done),
        .found     (sat),
        .int_vals  (int_vals),
        .bool_vals (bool_vals),
        .attempts  (attempts)
    );

endmodule

// ==== verilog/solution_select.sv ====
`timescale 1ns/1ns
/*
 * solution selector
 * keeps the first candidate meeting every clause, or gives up
 * when the last attempt comes back unsatisfied
 */
module solution_select
    import solver_cfg_pkg::*;
    import clause_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    candidate_if.sink                cand,
    input  sat_vec_t                 sat,
    output logic                     stop,
    output logic                     busy,
    output logic                     done,
    output logic                     found,
    output int_vals_t                int_vals,
    output bool_vals_t               bool_vals,
    output logic [attempt_width-1:0] attempts
);

    logic all_sat;
    logic last;       // final attempt of the run
    logic decide;

    assign all_sat = &sat;
    assign last    = cand.attempt == attempt_width'(max_attempts - 1);
    assign decide  = busy && cand.valid && (all_sat || last);  // late arrivals dropped

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy  <= 1'b0;
            stop  <= 1'b0;
            done  <= 1'b0;
            found <= 1'b0;
        end
        else
        begin
            done <= decide;             // one pulse, busy cannot re-decide
            if (start && !busy)
            begin
                busy  <= 1'b1;
                stop  <= 1'b0;          // release the generator
                found <= 1'b0;
            end
            else if (decide)
            begin
                busy  <= 1'b0;
                stop  <= 1'b1;
                found <= all_sat;       // low means limit reached
            end
        end
    end

    // result held until the next decision
    always_ff @(posedge clk)
    begin
        if (decide)
        begin
            int_vals  <= cand.int_vals;
            bool_vals <= cand.bool_vals;
            attempts  <= cand.attempt + 1'b1;   // max_attempts on failure
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        done |=> !done);

endmodule

// ==== verilog/solver_cfg_pkg.sv ====
/*
 * solver configuration
 * problem size, datapath widths, search limit and generator constants
 */
package solver_cfg_pkg;

    ////////////////////////////////////////////////////////////////////
    // problem size
    localparam int num_clauses   = 3;   // linear clauses checked per candidate
    localparam int num_int_vars  = 2;   // signed integer unknowns
    localparam int num_bool_vars = 2;   // boolean unknowns

    ////////////////////////////////////////////////////////////////////
    // datapath widths
    localparam int int_var_width = 8;   // integer value and coefficient, signed
    localparam int bias_width    = 8;   // clause bias, signed

    // a0*y0 + a1*y1 + bias never exceeds 2*2^14 + 2^7 in magnitude
    localparam int sum_width     = 18;

    ////////////////////////////////////////////////////////////////////
    // search control
    localparam int attempt_width = 8;   // holds max_attempts itself
    localparam int max_attempts  = 200; // candidates tried before giving up

    ////////////////////////////////////////////////////////////////////
    // candidate generator
    localparam int lfsr_width = 32;

    // any nonzero start state works, all-zero would lock up
    localparam logic [lfsr_width-1:0] lfsr_seed = 32'h5eed_c0de;

    // x^32 + x^22 + x^2 + x + 1, right-shifting galois form
    localparam logic [lfsr_width-1:0] lfsr_taps = 32'h8020_0003;

endpackage
